/* rob_defs.svh */
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// reorder buffer geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 4   // log2 of ROB_DEPTH

// datapath
`define XLEN      32  // data and pc width
`define REG_W     5   // architectural register number

`endif

/* rob_pkg.sv */
`include "rob_defs.svh"

package rob_pkg;

   // kind_none on the issue port means nothing offered
   typedef enum logic [1:0] {
      kind_alu    = 2'd0,
      kind_load   = 2'd1,
      kind_branch = 2'd2,
      kind_none   = 2'd3
   } inst_kind_t;

   // head/tail pointer, extra msb tells full from empty
   typedef logic [$clog2(`ROB_DEPTH):0] rob_ptr_t;

   typedef struct packed {
      inst_kind_t          kind;
      logic [`REG_W-1:0]   dest;       // zero for branches
      logic [`XLEN-1:0]    value;      // result, or branch outcome
      logic                busy;
      logic                ready;
      logic                pred_taken;
      logic [`XLEN-1:0]    pred_pc;
      logic [`XLEN-1:0]    taken_pc;   // pc4 + shifted offset
      logic [`XLEN-1:0]    pc4;        // fall-through
   } rob_entry_t;

endpackage

/* result_bus.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module result_bus (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  alu_req,
   input  logic [`ROB_TAG_W-1:0] alu_tag,
   input  logic [`XLEN-1:0]      alu_value,
   input  logic                  load_req,
   input  logic [`ROB_TAG_W-1:0] load_tag,
   input  logic [`XLEN-1:0]      load_value,
   output logic                  alu_grant,
   output logic                  load_grant,
   output logic                  cdb_valid,
   output logic [`ROB_TAG_W-1:0] cdb_tag,
   output logic [`XLEN-1:0]      cdb_value
);

   logic last_load;  // load won the last contested or single grant

   // round robin, loser of the last grant goes first
   assign alu_grant  = alu_req & (~load_req | last_load);
   assign load_grant = load_req & (~alu_req | ~last_load);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         last_load <= 1'b1;  // alu first out of reset
      end else if (alu_grant) begin
         last_load <= 1'b0;
      end else if (load_grant) begin
         last_load <= 1'b1;
      end
   end

   assign cdb_valid = alu_grant | load_grant;
   assign cdb_tag   = load_grant ? load_tag : alu_tag;
   assign cdb_value = load_grant ? load_value : alu_value;

   // contested cycle goes to whoever did not win the previous grant
   a_round_robin: assert property (@(posedge clk) disable iff (!rst)
      (alu_req && load_req && $past(cdb_valid)) |-> (load_grant == $past(alu_grant)))
      else $error("contested grant did not alternate");

endmodule

/* branch_check.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module branch_check (
   input  logic                head_valid,
   input  rob_pkg::rob_entry_t head_entry,
   output logic                mispredict,
   output logic [`XLEN-1:0]    pc_resolved
);

   import rob_pkg::*;

   logic head_branch;
   logic taken;
   logic dir_miss;
   logic tgt_miss;

   assign head_branch = head_valid && head_entry.ready && head_entry.kind == kind_branch;
   assign taken       = |head_entry.value;  // bne: nonzero difference means taken

   assign dir_miss = head_branch && (taken != head_entry.pred_taken);
   // only a taken prediction carries a target worth checking
   assign tgt_miss = head_branch && head_entry.pred_taken &&
                     (head_entry.pred_pc != head_entry.taken_pc);

   assign mispredict = dir_miss | tgt_miss;

   always_comb begin
      if (dir_miss) begin
         pc_resolved = head_entry.pred_taken ? head_entry.pc4 : head_entry.taken_pc;
      end else if (tgt_miss) begin
         pc_resolved = head_entry.taken_pc;
      end else begin
         pc_resolved = head_entry.pred_pc;
      end
   end

   // pointer-based head_valid must agree with the busy bit kept in the core
   always_comb begin
      assert (!mispredict || (head_valid && head_entry.busy && head_entry.ready &&
                              head_entry.kind == kind_branch))
         else $error("mispredict without a ready branch at the head");
   end

endmodule

/* rob_core.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_core (
   input  logic                  clk,
   input  logic                  rst,
   input  rob_pkg::inst_kind_t   issue_kind,
   input  logic [`REG_W-1:0]     issue_dest,
   input  logic [`XLEN-1:0]      issue_pc4,
   input  logic [`XLEN-1:0]      issue_offset,  // already shifted
   input  logic                  issue_pred_taken,
   input  logic [`XLEN-1:0]      issue_pred_pc,
   input  logic                  cdb_valid,
   input  logic [`ROB_TAG_W-1:0] cdb_tag,
   input  logic [`XLEN-1:0]      cdb_value,
   input  logic                  mispredict,
   output logic                  stall,
   output logic [`ROB_TAG_W-1:0] alloc_tag,
   output rob_pkg::rob_entry_t   head_entry,
   output logic                  head_valid,
   output logic                  commit_valid,
   output logic [`REG_W-1:0]     commit_dest,
   output logic [`XLEN-1:0]      commit_value
);

   import rob_pkg::*;

   rob_entry_t entries [`ROB_DEPTH];
   rob_entry_t new_entry;

   rob_ptr_t              head_ptr;
   rob_ptr_t              tail_ptr;
   logic [`ROB_TAG_W-1:0] head_idx;
   logic [`ROB_TAG_W-1:0] tail_idx;

   logic full;
   logic issue_ok;
   logic retire;
   logic commit_next;

   // ----------------------------------------
   // pointers and status
   // ----------------------------------------
   assign head_idx = head_ptr[`ROB_TAG_W-1:0];
   assign tail_idx = tail_ptr[`ROB_TAG_W-1:0];

   assign full = (head_ptr[`ROB_TAG_W] != tail_ptr[`ROB_TAG_W]) && (head_idx == tail_idx);

   assign stall      = full;
   assign alloc_tag  = tail_idx;
   assign head_valid = head_ptr != tail_ptr;
   assign head_entry = entries[head_idx];

   assign issue_ok    = !stall && !mispredict && issue_kind != kind_none;
   assign retire      = head_valid && head_entry.ready && !mispredict;
   assign commit_next = retire && head_entry.kind != kind_branch;  // branches retire silently

   // ----------------------------------------
   // entry built at allocation
   // ----------------------------------------
   always_comb begin
      new_entry            = '0;
      new_entry.kind       = issue_kind;
      new_entry.busy       = 1'b1;
      new_entry.pred_pc    = issue_pred_pc;
      new_entry.taken_pc   = issue_pc4 + issue_offset;
      new_entry.pc4        = issue_pc4;
      if (issue_kind == kind_alu || issue_kind == kind_load) begin
         new_entry.dest = issue_dest;
      end
      if (issue_kind == kind_branch) begin
         new_entry.pred_taken = issue_pred_taken;
      end
   end

   // ----------------------------------------
   // result write, issue, retire and flush
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         head_ptr     <= '0;
         tail_ptr     <= '0;
         commit_valid <= 1'b0;
         for (int i = 0; i < `ROB_DEPTH; i++) begin
            entries[i] <= '0;
         end
      end else if (mispredict) begin
         // slots outside head..tail are already empty, so clear them all
         for (int i = 0; i < `ROB_DEPTH; i++) begin
            entries[i] <= '0;
         end
         head_ptr     <= tail_ptr;  // branch itself is dropped too
         commit_valid <= 1'b0;
      end else begin
         if (cdb_valid && entries[cdb_tag].busy) begin
            entries[cdb_tag].value <= cdb_value;
            entries[cdb_tag].ready <= 1'b1;
         end

         if (retire) begin
            entries[head_idx] <= '0;
            head_ptr          <= head_ptr + 1'b1;
         end
         commit_valid <= commit_next;

         // tail slot is free here, full blocks issue via stall
         if (issue_ok) begin
            entries[tail_idx] <= new_entry;
            tail_ptr          <= tail_ptr + 1'b1;
         end
      end
   end

   // commit payload, held alongside the pulse
   always_ff @(posedge clk) begin
      if (commit_next) begin
         commit_dest  <= head_entry.dest;
         commit_value <= head_entry.value;
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   a_stall_holds: assert property (@(posedge clk) disable iff (!rst)
      stall |=> $stable(tail_ptr))
      else $error("entry allocated while stalled");

   // producers only ever hold tags of live entries
   a_cdb_busy: assert property (@(posedge clk) disable iff (!rst)
      (cdb_valid && !mispredict) |-> entries[cdb_tag].busy)
      else $error("result written to an idle entry");

   a_flush_no_commit: assert property (@(posedge clk) disable iff (!rst)
      mispredict |=> !commit_valid && head_ptr == $past(tail_ptr))
      else $error("mispredicted branch also committed");

endmodule

/* rob_top.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_top (
   input  logic                  clk,
   input  logic                  rst,
   input  rob_pkg::inst_kind_t   issue_kind,
   input  logic [`REG_W-1:0]     issue_dest,
   input  logic [`XLEN-1:0]      issue_pc4,
   input  logic [`XLEN-1:0]      issue_offset,
   input  logic                  issue_pred_taken,
   input  logic [`XLEN-1:0]      issue_pred_pc,
   input  logic                  alu_req,
   input  logic [`ROB_TAG_W-1:0] alu_tag,
   input  logic [`XLEN-1:0]      alu_value,
   input  logic                  load_req,
   input  logic [`ROB_TAG_W-1:0] load_tag,
   input  logic [`XLEN-1:0]      load_value,
   output logic                  alu_grant,
   output logic                  load_grant,
   output logic                  stall,
   output logic [`ROB_TAG_W-1:0] alloc_tag,
   output logic                  commit_valid,
   output logic [`REG_W-1:0]     commit_dest,
   output logic [`XLEN-1:0]      commit_value,
   output logic                  mispredict,
   output logic [`XLEN-1:0]      pc_resolved
);

   import rob_pkg::*;

   logic                  cdb_valid;
   logic [`ROB_TAG_W-1:0] cdb_tag;
   logic [`XLEN-1:0]      cdb_value;
   rob_entry_t            head_entry;
   logic                  head_valid;

   // ----------------------------------------
   // completion path
   // ----------------------------------------
   result_bus i_result_bus (
      .clk        (clk),
      .rst        (rst),
      .alu_req    (alu_req),
      .alu_tag    (alu_tag),
      .alu_value  (alu_value),
      .load_req   (load_req),
      .load_tag   (load_tag),
      .load_value (load_value),
      .alu_grant  (alu_grant),
      .load_grant (load_grant),
      .cdb_valid  (cdb_valid),
      .cdb_tag    (cdb_tag),
      .cdb_value  (cdb_value)
   );

   rob_core i_rob_core (
      .clk              (clk),
      .rst              (rst),
      .issue_kind       (issue_kind),
      .issue_dest       (issue_dest),
      .issue_pc4        (issue_pc4),
      .issue_offset     (issue_offset),
      .issue_pred_taken (issue_pred_taken),
      .issue_pred_pc    (issue_pred_pc),
      .cdb_valid        (cdb_valid),
      .cdb_tag          (cdb_tag),
      .cdb_value        (cdb_value),
      .mispredict       (mispredict),
      .stall            (stall),
      .alloc_tag        (alloc_tag),
      .head_entry       (head_entry),
      .head_valid       (head_valid),
      .commit_valid     (commit_valid),
      .commit_dest      (commit_dest),
      .commit_value     (commit_value)
   );

   // head branch resolution, feeds the flush back into the core
   branch_check i_branch_check (
      .head_valid  (head_valid),
      .head_entry  (head_entry),
      .mispredict  (mispredict),
      .pc_resolved (pc_resolved)
   );

endmodule

/* rob_checker.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_checker (
   input  logic                  clk,
   input  logic                  rst,
   input  rob_pkg::inst_kind_t   issue_kind,
   input  logic [`ROB_TAG_W-1:0] alloc_tag,
   input  logic                  commit_valid,
   input  logic [`REG_W-1:0]     commit_dest,
   input  logic [`XLEN-1:0]      commit_value,
   input  logic                  mispredict,
   input  logic [`XLEN-1:0]      pc_resolved,
   input  logic                  stall,
   input  logic                  alu_req,
   input  logic                  alu_grant,
   input  logic                  load_req,
   input  logic                  load_grant,
   input  logic                  exp_commit,
   input  logic [`REG_W-1:0]     exp_dest,
   input  logic [`XLEN-1:0]      exp_value,
   input  logic                  exp_redirect,
   input  logic [`XLEN-1:0]      exp_pc,
   input  logic [1:0]            exp_stall,   // 2 means not checked
   input  logic                  done,
   output logic                  idle,
   output int                    errors
);

   import rob_pkg::*;

   logic [`REG_W-1:0] dest_q [$];
   logic [`XLEN-1:0]  value_q [$];
   logic [`XLEN-1:0]  pc_q [$];
   logic              alu_pend;
   logic              load_pend;
   logic [`ROB_TAG_W-1:0] exp_tag;  // next tag in allocation order
   logic              load_first;   // load holds the round-robin priority
   logic              exp_alu_gnt;
   logic              exp_load_gnt;
   int                value_errs;
   int                event_errs;

   initial begin
      idle       = 1'b1;
      alu_pend   = 1'b0;
      load_pend  = 1'b0;
      exp_tag    = '0;
      load_first = 1'b0;
      value_errs = 0;
      event_errs = 0;
   end

   assign errors = value_errs + event_errs;

   // ----------------------------------------
   // per-edge comparison
   // ----------------------------------------
   always @(posedge clk) begin
      if (rst) begin
         if (exp_commit) begin  // queue before popping, same edge may do both
            dest_q.push_back(exp_dest);
            value_q.push_back(exp_value);
         end
         if (exp_redirect) pc_q.push_back(exp_pc);

         if (commit_valid) begin
            if (dest_q.size() == 0) begin
               $display("ERR %0t: unexpected commit dest %0h value %0h",
                        $time, commit_dest, commit_value);
               event_errs++;
            end else begin
               if (commit_dest !== dest_q[0] || commit_value !== value_q[0]) begin
                  $display("ERR %0t: commit dest %0h value %0h, expected %0h %0h",
                           $time, commit_dest, commit_value, dest_q[0], value_q[0]);
                  value_errs++;
               end
               void'(dest_q.pop_front());
               void'(value_q.pop_front());
            end
         end

         if (mispredict) begin
            if (pc_q.size() == 0) begin
               $display("ERR %0t: unexpected redirect to %0h", $time, pc_resolved);
               event_errs++;
            end else begin
               if (pc_resolved !== pc_q[0]) begin
                  $display("ERR %0t: redirect to %0h, expected %0h",
                           $time, pc_resolved, pc_q[0]);
                  value_errs++;
               end
               void'(pc_q.pop_front());
            end
         end

         if (exp_stall != 2'd2 && stall !== exp_stall[0]) begin
            $display("ERR %0t: stall is %0b, expected %0b", $time, stall, exp_stall[0]);
            value_errs++;
         end

         // lone requester wins, a contested cycle goes to the last loser
         case ({alu_req, load_req})
            2'b10:   {exp_alu_gnt, exp_load_gnt} = 2'b10;
            2'b01:   {exp_alu_gnt, exp_load_gnt} = 2'b01;
            2'b11:   {exp_alu_gnt, exp_load_gnt} = load_first ? 2'b01 : 2'b10;
            default: {exp_alu_gnt, exp_load_gnt} = 2'b00;
         endcase
         if (alu_grant !== exp_alu_gnt || load_grant !== exp_load_gnt) begin
            $display("ERR %0t: grants alu %0b load %0b, expected %0b %0b",
                     $time, alu_grant, load_grant, exp_alu_gnt, exp_load_gnt);
            value_errs++;
         end
         if (exp_alu_gnt) begin
            load_first = 1'b1;
         end else if (exp_load_gnt) begin
            load_first = 1'b0;
         end

         if (issue_kind != kind_none) begin
            if (alloc_tag !== exp_tag) begin
               $display("ERR %0t: alloc tag %0h, expected %0h", $time, alloc_tag, exp_tag);
               value_errs++;
            end
            if (!stall && !mispredict) begin  // stall or flush drops the offer
               exp_tag = exp_tag + 1'b1;
            end
         end

         // a refused completion must be offered again
         if (alu_pend && !alu_req) begin
            $display("ERR %0t: alu completion dropped before its grant", $time);
            event_errs++;
         end
         if (load_pend && !load_req) begin
            $display("ERR %0t: load completion dropped before its grant", $time);
            event_errs++;
         end
         alu_pend  = alu_req && !alu_grant;
         load_pend = load_req && !load_grant;

         idle = dest_q.size() == 0 && pc_q.size() == 0;
      end
   end

   // ----------------------------------------
   // end of run
   // ----------------------------------------
   always @(posedge done) begin
      if (dest_q.size() != 0 || pc_q.size() != 0) begin
         $display("ERR %0t: %0d commits and %0d redirects never seen",
                  $time, dest_q.size(), pc_q.size());
         event_errs++;
      end
      if (alu_pend || load_pend) begin
         $display("ERR %0t: completion still pending at the end", $time);
         event_errs++;
      end
      $display("errors: %0d wrong values, %0d missing or unexpected events",
               value_errs, event_errs);
   end

endmodule

/* tb_rob.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module tb_rob;

   import rob_pkg::*;

   localparam int MAX_LINES = 64;
   localparam int NFIELDS   = 18;

   logic                  clk;
   logic                  rst;
   inst_kind_t            issue_kind;
   logic [`REG_W-1:0]     issue_dest;
   logic [`XLEN-1:0]      issue_pc4;
   logic [`XLEN-1:0]      issue_offset;
   logic                  issue_pred_taken;
   logic [`XLEN-1:0]      issue_pred_pc;
   logic                  alu_req;
   logic [`ROB_TAG_W-1:0] alu_tag;
   logic [`XLEN-1:0]      alu_value;
   logic                  load_req;
   logic [`ROB_TAG_W-1:0] load_tag;
   logic [`XLEN-1:0]      load_value;
   logic                  alu_grant;
   logic                  load_grant;
   logic                  stall;
   logic [`ROB_TAG_W-1:0] alloc_tag;
   logic                  commit_valid;
   logic [`REG_W-1:0]     commit_dest;
   logic [`XLEN-1:0]      commit_value;
   logic                  mispredict;
   logic [`XLEN-1:0]      pc_resolved;

   logic                  exp_commit;
   logic [`REG_W-1:0]     exp_dest;
   logic [`XLEN-1:0]      exp_value;
   logic                  exp_redirect;
   logic [`XLEN-1:0]      exp_pc;
   logic [1:0]            exp_stall;
   logic                  done;
   logic                  idle;
   int                    errors;

   logic [31:0] pat [MAX_LINES][NFIELDS];
   logic [31:0] fld [NFIELDS];
   logic        pat_ok;
   int          n_lines;
   int          cycles;

   rob_top i_dut (.*);

   rob_checker i_checker (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // runs out at the pattern length plus drain margin
   always @(posedge clk) begin
      cycles++;
      if (n_lines > 0 && cycles > n_lines + 40) begin
         $display("timeout: DUT never drained its expected events");
         $display("Test FAILED");
         $finish;
      end
   end

   // ----------------------------------------
   // pattern file
   // ----------------------------------------
   task automatic read_patterns(output logic opened);
      int    fd;
      int    cnt;
      string line;
      fd     = $fopen("rob_patterns.txt", "r");
      opened = fd != 0;
      if (opened) begin
         while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.substr(0, 0) != "#") begin
               cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                             fld[6], fld[7], fld[8], fld[9], fld[10], fld[11],
                             fld[12], fld[13], fld[14], fld[15], fld[16], fld[17]);
               if (cnt == NFIELDS) begin
                  for (int k = 0; k < NFIELDS; k++) pat[n_lines][k] = fld[k];
                  n_lines++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic apply_line(int i);
      issue_kind       = inst_kind_t'(pat[i][0][1:0]);
      issue_dest       = pat[i][1][`REG_W-1:0];
      issue_pc4        = pat[i][2];
      issue_offset     = pat[i][3];
      issue_pred_taken = pat[i][4][0];
      issue_pred_pc    = pat[i][5];
      alu_req          = pat[i][6][0];
      alu_tag          = pat[i][7][`ROB_TAG_W-1:0];
      alu_value        = pat[i][8];
      load_req         = pat[i][9][0];
      load_tag         = pat[i][10][`ROB_TAG_W-1:0];
      load_value       = pat[i][11];
      exp_commit       = pat[i][12][0];
      exp_dest         = pat[i][13][`REG_W-1:0];
      exp_value        = pat[i][14];
      exp_redirect     = pat[i][15][0];
      exp_pc           = pat[i][16];
      exp_stall        = pat[i][17][1:0];
   endtask

   task automatic drive_idle();
      issue_kind       = kind_none;
      issue_dest       = '0;
      issue_pc4        = '0;
      issue_offset     = '0;
      issue_pred_taken = 1'b0;
      issue_pred_pc    = '0;
      alu_req          = 1'b0;
      alu_tag          = '0;
      alu_value        = '0;
      load_req         = 1'b0;
      load_tag         = '0;
      load_value       = '0;
      exp_commit       = 1'b0;
      exp_dest         = '0;
      exp_value        = '0;
      exp_redirect     = 1'b0;
      exp_pc           = '0;
      exp_stall        = 2'd2;
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      rst     = 1'b0;
      done    = 1'b0;
      n_lines = 0;
      cycles  = 0;
      drive_idle();
      read_patterns(pat_ok);
      if (!pat_ok || n_lines == 0) begin
         $display("rob_patterns.txt is missing or holds no pattern lines");
         $display("Test FAILED");
         $finish;
      end else begin
         repeat (3) @(posedge clk);
         #2 rst = 1'b1;
         for (int i = 0; i < n_lines; i++) begin
            if (i > 0) begin
               @(posedge clk);
               #2;
            end
            apply_line(i);
         end
         @(posedge clk);
         #2 drive_idle();
         while (!idle) @(negedge clk);  // last commits still in flight
         @(posedge clk);
         #2 done = 1'b1;
         #1;
         if (errors == 0) begin
            $display("Test OK");
         end else begin
            $display("Test FAILED");
         end
         $finish;
      end
   end

endmodule

/* rob_patterns.txt */
# kind dest pc4 offset pred_taken pred_pc | alu_req alu_tag alu_value | load_req load_tag load_value
# exp_commit exp_dest exp_value | exp_redirect exp_pc | exp_stall (2 = unchecked), all hex
0 01 0 0 0 0 0 0 0 0 0 0 1 01 11 0 0 0
1 02 0 0 0 0 0 0 0 0 0 0 1 02 22 0 0 0
0 03 0 0 0 0 0 0 0 0 0 0 1 03 33 0 0 0
1 04 0 0 0 0 0 0 0 0 0 0 1 04 44 0 0 0
0 05 0 0 0 0 0 0 0 0 0 0 1 05 55 0 0 0
1 06 0 0 0 0 0 0 0 0 0 0 1 06 66 0 0 0
3 00 0 0 0 0 1 2 33 1 1 22 0 00 0 0 0 0
3 00 0 0 0 0 1 4 55 1 1 22 0 00 0 0 0 0
3 00 0 0 0 0 1 4 55 1 3 44 0 00 0 0 0 0
3 00 0 0 0 0 1 0 11 1 3 44 0 00 0 0 0 0
3 00 0 0 0 0 1 0 11 1 5 66 0 00 0 0 0 0
3 00 0 0 0 0 0 0 0 1 5 66 0 00 0 0 0 0
2 00 104 20 1 124 0 0 0 0 0 0 0 00 0 0 0 0
3 00 0 0 0 0 1 6 1 0 0 0 0 00 0 0 0 0
2 00 200 40 0 200 0 0 0 0 0 0 0 00 0 0 0 0
3 00 0 0 0 0 1 7 0 0 0 0 0 00 0 0 0 0
2 00 304 10 1 314 0 0 0 0 0 0 0 00 0 1 304 0
0 07 0 0 0 0 1 8 0 0 0 0 0 00 0 0 0 0
3 00 0 0 0 0 1 9 77 0 0 0 0 00 0 0 0 0
0 09 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
2 00 404 80 0 404 0 0 0 0 0 0 0 00 0 1 484 0
0 0a 0 0 0 0 1 a 5 0 0 0 0 00 0 0 0 0
3 00 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
2 00 504 8 1 600 0 0 0 0 0 0 0 00 0 1 50c 0
3 00 0 0 0 0 1 c 1 0 0 0 0 00 0 0 0 0
0 0e 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 0b 0 0 0 0 0 0 0 0 0 0 1 0b bb 0 0 0
3 00 0 0 0 0 1 d bb 0 0 0 0 00 0 0 0 0
0 10 0 0 0 0 0 0 0 0 0 0 1 10 e0 0 0 0
0 11 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 12 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 13 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 14 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 15 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 16 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 17 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 18 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 19 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 1a 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 1b 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 1c 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 1d 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 1e 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 1f 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0
0 01 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 1
0 02 0 0 0 0 1 e e0 0 0 0 0 00 0 0 0 1
0 03 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 1
3 00 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0

/* sources.f */
+incdir+.
rob_pkg.sv
result_bus.sv
branch_check.sv
rob_core.sv
rob_top.sv
rob_checker.sv
tb_rob.sv

/* run.sh */
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_rob -o sim_rob
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_rob > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" sim.log; then
   exit 1
fi
exit 0
